//--- rtl/tile_pkg.sv
//********************
// shared types of the peripheral tile
// TileLink-UL A and D channel structs
// plain device request and response
// device select and response metadata
// opcodes and address map
//********************
package tile_pkg;

  // A channel opcodes
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  typedef enum logic [1:0] {
    DevRam,
    DevSimCtrl,
    DevTestRst,
    DevNone
  } dev_e;

  typedef struct packed {
    logic        a_valid;
    tl_a_op_e    a_opcode;
    logic [31:0] a_address;
    logic [3:0]  a_mask;
    logic [31:0] a_data;
    logic [7:0]  a_source;
    logic [1:0]  a_size;
  } tl_h2d_t;

  typedef struct packed {
    logic        d_valid;
    tl_d_op_e    d_opcode;
    logic [31:0] d_data;
    logic        d_error;
    logic [7:0]  d_source;
    logic [1:0]  d_size;
    logic        a_ready;
  } tl_d2h_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dev_req_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } dev_rsp_t;

  // what the result stage needs to answer an accepted request
  typedef struct packed {
    dev_e       sel;
    logic       is_write;
    logic [7:0] source;
    logic [1:0] size;
  } rsp_meta_t;

  // address map, the RAM window size comes from RamDepth
  localparam logic [31:0] RamBase       = 32'h0010_0000;
  localparam logic [31:0] SimCtrlBase   = 32'h0002_0000;
  localparam logic [31:0] SimCharOffset = 32'h0000_0000;
  localparam logic [31:0] SimHaltOffset = 32'h0000_0008;
  localparam logic [31:0] SimCtrlSize   = 32'h0000_0400;
  localparam logic [31:0] TestRstBase   = 32'h0003_0000;
  localparam logic [31:0] TestRstSize   = 32'h0000_0010;

endpackage

//--- rtl/tl_addr_decode.sv
//********************
// address decoder
// A channel to per-device requests
// response metadata for the result stage
//********************
`timescale 1ns/1ps

module tl_addr_decode #(
  parameter int unsigned RamDepth = 1024
) (
  input  tile_pkg::tl_h2d_t   tl_i,
  output tile_pkg::dev_req_t  ram_req_o,
  output tile_pkg::dev_req_t  sim_req_o,
  output tile_pkg::dev_req_t  test_req_o,
  output tile_pkg::rsp_meta_t meta_o,
  output logic                meta_valid_o
);
  import tile_pkg::*;

  localparam logic [31:0] RamSize = 32'(RamDepth * 4);

  dev_e     sel;
  logic     is_write;
  dev_req_t req_base;

  // unsigned offset compare, addresses below a base wrap to large values
  always_comb begin
    sel = DevNone;
    if (tl_i.a_address - RamBase < RamSize) begin
      sel = DevRam;
    end else if (tl_i.a_address - SimCtrlBase < SimCtrlSize) begin
      sel = DevSimCtrl;
    end else if (tl_i.a_address - TestRstBase < TestRstSize) begin
      sel = DevTestRst;
    end
  end

  assign is_write = (tl_i.a_opcode == PutFullData) || (tl_i.a_opcode == PutPartialData);

  always_comb begin
    req_base       = '0;
    req_base.we    = is_write;
    req_base.be    = tl_i.a_mask;
    req_base.addr  = tl_i.a_address;
    req_base.wdata = tl_i.a_data;
    ram_req_o      = req_base;
    sim_req_o      = req_base;
    test_req_o     = req_base;
    // only the addressed device sees req
    ram_req_o.req  = tl_i.a_valid && (sel == DevRam);
    sim_req_o.req  = tl_i.a_valid && (sel == DevSimCtrl);
    test_req_o.req = tl_i.a_valid && (sel == DevTestRst);
  end

  always_comb begin
    meta_o.sel      = sel;
    meta_o.is_write = is_write;
    meta_o.source   = tl_i.a_source;
    meta_o.size     = tl_i.a_size;
  end

  assign meta_valid_o = tl_i.a_valid;

  always_comb begin
    assert final ($onehot0({ram_req_o.req, sim_req_o.req, test_req_o.req}))
      else $error("decode: more than one device request");
  end

endmodule

//--- rtl/data_ram.sv
//********************
// single-port data RAM
// byte-masked writes, registered read data
//********************
`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned RamDepth = 1024
) (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  tile_pkg::dev_req_t req_i,
  output tile_pkg::dev_rsp_t rsp_o
);

  localparam int unsigned AddrW = $clog2(RamDepth);

  logic [31:0]      mem [RamDepth];
  logic [AddrW-1:0] word_idx;
  logic [31:0]      rdata_q;
  logic             rvalid_q;

  // word address, wraps modulo the depth
  assign word_idx = req_i.addr[AddrW+1:2];

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // a write returns the word as it was before the merge
  always_ff @(posedge clk_sys) begin
    if (req_i.req) begin
      rdata_q <= mem[word_idx];
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  a_rvalid_follows_req: assert property (
    @(posedge clk_sys) disable iff (!rst_sys_n)
    req_i.req |=> rsp_o.rvalid
  ) else $error("data_ram: rvalid missing one cycle after req");

endmodule

//--- rtl/sim_ctrl.sv
//********************
// simulator control device
// character output strobe
// sticky halt level
//********************
`timescale 1ns/1ps

module sim_ctrl (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  tile_pkg::dev_req_t req_i,
  output tile_pkg::dev_rsp_t rsp_o,
  output logic               char_valid_o,
  output logic [7:0]         char_o,
  output logic               halt_o
);
  import tile_pkg::*;

  logic [31:0] offset;
  logic        char_wr;
  logic        halt_wr;
  logic        char_valid_q;
  logic [7:0]  char_q;
  logic        halt_q;
  logic        rvalid_q;

  assign offset  = req_i.addr - SimCtrlBase;
  assign char_wr = req_i.req && req_i.we && (offset == SimCharOffset);
  assign halt_wr = req_i.req && req_i.we && (offset == SimHaltOffset);

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      char_valid_q <= char_wr;
      rvalid_q     <= req_i.req;
      // halt holds until the next reset
      if (halt_wr) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (char_wr) begin
      char_q <= req_i.wdata[7:0];
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;
  // nothing readable here
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = '0;

endmodule

//--- rtl/test_rst_ctrl.sv
//********************
// test-reset trigger
// LOW, VALIDATE, HIGH sequence
// acknowledges every access
//********************
`timescale 1ns/1ps

module test_rst_ctrl (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  tile_pkg::dev_req_t req_i,
  output tile_pkg::dev_rsp_t rsp_o,
  output logic               test_reset_o
);

  typedef enum logic [1:0] {
    StLow,
    StValidate,
    StHigh
  } trig_state_e;

  trig_state_e state_q;
  trig_state_e state_d;
  logic        rvalid_q;

  // first access arms the trigger, HIGH is terminal
  always_comb begin
    state_d = state_q;
    case (state_q)
      StLow: begin
        if (req_i.req) begin
          state_d = StValidate;
        end
      end
      StValidate: state_d = StHigh;
      StHigh:     state_d = StHigh;
      default:    state_d = StLow;
    endcase
  end

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      state_q  <= StLow;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= req_i.req;
    end
  end

  assign test_reset_o = (state_q == StHigh);
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = '0;

  a_test_reset_sticky: assert property (
    @(posedge clk_sys) disable iff (!rst_sys_n)
    test_reset_o |=> test_reset_o
  ) else $error("test_rst_ctrl: test_reset fell before reset");

endmodule

//--- rtl/tl_rsp_mux.sv
//********************
// response mux
// registers request metadata
// assembles the D channel
//********************
`timescale 1ns/1ps

module tl_rsp_mux (
  input  logic                clk_sys,
  input  logic                rst_sys_n,
  input  tile_pkg::rsp_meta_t meta_i,
  input  logic                meta_valid_i,
  input  tile_pkg::dev_rsp_t  ram_rsp_i,
  input  tile_pkg::dev_rsp_t  sim_rsp_i,
  input  tile_pkg::dev_rsp_t  test_rsp_i,
  output tile_pkg::tl_d2h_t   tl_o
);
  import tile_pkg::*;

  rsp_meta_t meta_q;
  logic      err_q;
  dev_rsp_t  sel_rsp;

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      meta_q <= '0;
      err_q  <= 1'b0;
    end else begin
      // unmapped access answers on its own next cycle
      err_q <= meta_valid_i && (meta_i.sel == DevNone);
      if (meta_valid_i) begin
        meta_q <= meta_i;
      end
    end
  end

  always_comb begin
    case (meta_q.sel)
      DevRam:     sel_rsp = ram_rsp_i;
      DevSimCtrl: sel_rsp = sim_rsp_i;
      DevTestRst: sel_rsp = test_rsp_i;
      default:    sel_rsp = '0;
    endcase
  end

  always_comb begin
    tl_o          = '0;
    tl_o.a_ready  = 1'b1;
    tl_o.d_valid  = err_q || sel_rsp.rvalid;
    tl_o.d_opcode = meta_q.is_write ? AccessAck : AccessAckData;
    tl_o.d_data   = err_q ? '0 : sel_rsp.rdata;
    tl_o.d_error  = err_q;
    tl_o.d_source = meta_q.source;
    tl_o.d_size   = meta_q.size;
  end

  a_rvalid_from_sel: assert property (
    @(posedge clk_sys) disable iff (!rst_sys_n)
    (ram_rsp_i.rvalid -> meta_q.sel == DevRam) &&
    (sim_rsp_i.rvalid -> meta_q.sel == DevSimCtrl) &&
    (test_rsp_i.rvalid -> meta_q.sel == DevTestRst)
  ) else $error("rsp_mux: rvalid from a device that was not selected");

endmodule

//--- rtl/periph_tile.sv
//********************
// peripheral tile top level
// decoder, RAM, sim control,
// test-reset trigger, response mux
//********************
`timescale 1ns/1ps

module periph_tile #(
  parameter int unsigned RamDepth = 1024
) (
  input  logic              clk_sys,
  input  logic              rst_sys_n,
  input  tile_pkg::tl_h2d_t tl_i,
  output tile_pkg::tl_d2h_t tl_o,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              halt_o,
  output logic              test_reset_o
);
  import tile_pkg::*;

  dev_req_t  ram_req;
  dev_req_t  sim_req;
  dev_req_t  test_req;
  dev_rsp_t  ram_rsp;
  dev_rsp_t  sim_rsp;
  dev_rsp_t  test_rsp;
  rsp_meta_t meta;
  logic      meta_valid;

  tl_addr_decode #(
    .RamDepth (RamDepth)
  ) u_decode (
    .tl_i         (tl_i),
    .ram_req_o    (ram_req),
    .sim_req_o    (sim_req),
    .test_req_o   (test_req),
    .meta_o       (meta),
    .meta_valid_o (meta_valid)
  );

  data_ram #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_sys_n),
    .req_i     (ram_req),
    .rsp_o     (ram_rsp)
  );

  sim_ctrl u_sim_ctrl (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .req_i        (sim_req),
    .rsp_o        (sim_rsp),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  test_rst_ctrl u_test_rst (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .req_i        (test_req),
    .rsp_o        (test_rsp),
    .test_reset_o (test_reset_o)
  );

  tl_rsp_mux u_rsp_mux (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .meta_i       (meta),
    .meta_valid_i (meta_valid),
    .ram_rsp_i    (ram_rsp),
    .sim_rsp_i    (sim_rsp),
    .test_rsp_i   (test_rsp),
    .tl_o         (tl_o)
  );

endmodule

//--- sim/tb_periph_tile.sv
//********************
// testbench for the peripheral tile
// clock, reset and stimulus on falling edges
// RAM model and expected response queue
// concurrent checks on the D channel and strobes
//********************
`timescale 1ns/1ps

module tb_periph_tile;
  import tile_pkg::*;

  localparam int unsigned RamDepth      = 1024;
  localparam int unsigned TimeoutCycles = 3000;

  // one expected cycle of DUT output
  typedef struct packed {
    logic        valid;
    logic [2:0]  op;
    logic [31:0] data;
    logic        err;
    logic [7:0]  src;
    logic [1:0]  size;
    logic        chr_valid;
    logic [7:0]  chr;
  } exp_rsp_t;

  logic        clk_sys;
  logic        rst_sys_n;
  tl_h2d_t     tl_i;
  tl_d2h_t     tl_o;
  logic        char_valid_o;
  logic [7:0]  char_o;
  logic        halt_o;
  logic        test_reset_o;

  logic [31:0] ram_model [RamDepth];
  exp_rsp_t    exp_q [$];
  exp_rsp_t    exp_now;
  logic        halt_pend;
  logic        halt_exp;
  int          trst_phase;
  logic        trst_exp;
  int          cycle_cnt = 0;
  integer      seed;

  periph_tile #(
    .RamDepth (RamDepth)
  ) periph_tile_i (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .tl_i         (tl_i),
    .tl_o         (tl_o),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o),
    .test_reset_o (test_reset_o)
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, want);
    abort_run();
  endtask

  // expected response of one request, model updated in request order
  task automatic push_expect(input tl_h2d_t a);
    exp_rsp_t    e;
    logic        wr;
    int unsigned idx;
    logic [31:0] off;
    e        = '0;
    wr       = (a.a_opcode != Get);
    e.valid  = 1'b1;
    e.op     = wr ? 3'h0 : 3'h1;
    e.src    = a.a_source;
    e.size   = a.a_size;
    if (a.a_address >= RamBase && a.a_address < RamBase + RamDepth * 4) begin
      idx    = (a.a_address >> 2) % RamDepth;
      // old word comes back for reads and writes
      e.data = ram_model[idx];
      if (wr) begin
        for (int b = 0; b < 4; b++) begin
          if (a.a_mask[b]) begin
            ram_model[idx][8*b +: 8] = a.a_data[8*b +: 8];
          end
        end
      end
    end else if (a.a_address >= SimCtrlBase && a.a_address < SimCtrlBase + SimCtrlSize) begin
      off = a.a_address - SimCtrlBase;
      if (wr && off == SimCharOffset) begin
        e.chr_valid = 1'b1;
        e.chr       = a.a_data[7:0];
      end
      if (wr && off == SimHaltOffset) begin
        halt_pend = 1'b1;
      end
    end else if (a.a_address >= TestRstBase && a.a_address < TestRstBase + TestRstSize) begin
      if (trst_phase == 0) begin
        trst_phase = 1;
      end
    end else begin
      e.err = 1'b1;
    end
    exp_q.push_back(e);
  endtask

  // one clock edge has passed since the last call
  task automatic advance_expect();
    exp_now = '0;
    if (exp_q.size() > 0) begin
      exp_now = exp_q.pop_front();
    end
    if (halt_pend) begin
      halt_exp = 1'b1;
    end
    halt_pend = 1'b0;
    // pending, then VALIDATE, then HIGH
    if (trst_phase == 1 || trst_phase == 2) begin
      trst_phase++;
    end
    trst_exp = (trst_phase == 3);
  endtask

  task automatic drive_cycle(input tl_h2d_t a);
    @(negedge clk_sys);
    advance_expect();
    tl_i = a;
    if (a.a_valid) begin
      push_expect(a);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle('0);
  endtask

  function automatic tl_h2d_t make_req(input tl_a_op_e op, input logic [31:0] addr,
                                       input logic [31:0] data, input logic [3:0] mask);
    tl_h2d_t a;
    a           = '0;
    a.a_valid   = 1'b1;
    a.a_opcode  = op;
    a.a_address = addr;
    a.a_data    = data;
    a.a_mask    = (op == PutPartialData && mask != 4'h0) ? mask : 4'hf;
    a.a_source  = $random(seed);
    a.a_size    = $random(seed);
    return a;
  endfunction

  // small word set so reads hit earlier writes
  function automatic logic [31:0] ram_addr();
    return RamBase + (($random(seed) & 32'h1f) << 2);
  endfunction

  a_d_valid: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    tl_o.d_valid == exp_now.valid)
    else flag_mismatch("tl_o.d_valid", $sampled(tl_o.d_valid), exp_now.valid);
  a_d_opcode: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    exp_now.valid |-> tl_o.d_opcode == exp_now.op)
    else flag_mismatch("tl_o.d_opcode", $sampled(tl_o.d_opcode), exp_now.op);
  a_d_data: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    exp_now.valid |-> tl_o.d_data === exp_now.data)
    else flag_mismatch("tl_o.d_data", $sampled(tl_o.d_data), exp_now.data);
  a_d_error: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    exp_now.valid |-> tl_o.d_error == exp_now.err)
    else flag_mismatch("tl_o.d_error", $sampled(tl_o.d_error), exp_now.err);
  a_d_source: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    exp_now.valid |-> tl_o.d_source == exp_now.src)
    else flag_mismatch("tl_o.d_source", $sampled(tl_o.d_source), exp_now.src);
  a_d_size: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    exp_now.valid |-> tl_o.d_size == exp_now.size)
    else flag_mismatch("tl_o.d_size", $sampled(tl_o.d_size), exp_now.size);
  // no back-pressure, every request is taken
  a_ready_high: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    tl_o.a_ready == 1'b1)
    else flag_mismatch("tl_o.a_ready", $sampled(tl_o.a_ready), 1'b1);
  a_char_valid: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    char_valid_o == exp_now.chr_valid)
    else flag_mismatch("char_valid_o", $sampled(char_valid_o), exp_now.chr_valid);
  a_char: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    exp_now.chr_valid |-> char_o == exp_now.chr)
    else flag_mismatch("char_o", $sampled(char_o), exp_now.chr);
  a_halt: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    halt_o == halt_exp)
    else flag_mismatch("halt_o", $sampled(halt_o), halt_exp);
  a_test_reset: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
    test_reset_o == trst_exp)
    else flag_mismatch("test_reset_o", $sampled(test_reset_o), trst_exp);

  initial begin
    wait (cycle_cnt >= TimeoutCycles);
    $display("timeout: test sequence did not finish within %0d cycles", TimeoutCycles);
    abort_run();
  end

  initial begin
    tl_a_op_e op;
    int       r;
    seed       = 32'hb08c6736;
    tl_i       = '0;
    rst_sys_n  = 1'b0;
    exp_now    = '0;
    halt_pend  = 1'b0;
    halt_exp   = 1'b0;
    trst_phase = 0;
    trst_exp   = 1'b0;
    repeat (8) @(negedge clk_sys);
    rst_sys_n = 1'b1;
    idle_cycles(4);

    // RAM writes, full and partial, then reads
    repeat (120) begin
      op = ($random(seed) & 1) ? PutFullData : PutPartialData;
      drive_cycle(make_req(op, ram_addr(), $random(seed), $random(seed)));
      idle_cycles($random(seed) & 1);
    end
    repeat (120) begin
      drive_cycle(make_req(Get, ram_addr(), 32'h0, 4'hf));
      idle_cycles($random(seed) & 1);
    end

    // back-to-back mix of RAM and sim control
    repeat (400) begin
      r = $random(seed) & 7;
      if (r < 3) begin
        drive_cycle(make_req(PutPartialData, ram_addr(), $random(seed), $random(seed)));
      end else if (r < 5) begin
        drive_cycle(make_req(Get, ram_addr(), 32'h0, 4'hf));
      end else if (r == 5) begin
        drive_cycle(make_req(PutFullData, SimCtrlBase + SimCharOffset, $random(seed), 4'hf));
      end else begin
        drive_cycle(make_req(Get, SimCtrlBase + 32'h4, 32'h0, 4'hf));
      end
    end
    idle_cycles(2);

    // character strobe, then sticky halt
    drive_cycle(make_req(PutFullData, SimCtrlBase + SimCharOffset, 32'h0000_005a, 4'hf));
    idle_cycles(2);
    drive_cycle(make_req(PutFullData, SimCtrlBase + SimHaltOffset, 32'h1, 4'hf));
    idle_cycles(5);

    // addresses outside every window
    drive_cycle(make_req(Get, 32'h0004_0000, 32'h0, 4'hf));
    drive_cycle(make_req(PutFullData, RamBase - 32'h4, 32'hdead_beef, 4'hf));
    drive_cycle(make_req(Get, SimCtrlBase + SimCtrlSize, 32'h0, 4'hf));
    idle_cycles(2);

    // test-reset trigger and a later access
    drive_cycle(make_req(Get, TestRstBase, 32'h0, 4'hf));
    idle_cycles(4);
    drive_cycle(make_req(PutFullData, TestRstBase + 32'h4, 32'h1, 4'hf));
    idle_cycles(4);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- compile.f
rtl/tile_pkg.sv
rtl/tl_addr_decode.sv
rtl/data_ram.sv
rtl/sim_ctrl.sv
rtl/test_rst_ctrl.sv
rtl/tl_rsp_mux.sv
rtl/periph_tile.sv
sim/tb_periph_tile.sv
